//--- exu_top.f
exu_pkg.sv
alu.sv
exu.sv
regfile.sv
lsu.sv
exu_top.sv
tb_clock.sv
exu_props.sv
exu_tb.sv

//--- run.sh
#!/bin/sh
# build the execute cluster testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module exu_tb \
	-f exu_top.f \
	-o exu_sim

./obj_dir/exu_sim

//--- exu_tb.sv
/*
 * exu_tb
 * directed tests for the execute cluster: ALU ops, operand selects,
 * branches, word and subword stores and loads
 */
`timescale 1ns/10ps
module exu_tb;

	logic                  clk_i;
	logic                  rst_n_i;
	logic                  issue_i;
	exu_pkg::reg_addr_t    rs1_i;
	exu_pkg::reg_addr_t    rs2_i;
	exu_pkg::reg_addr_t    rd_i;
	logic                  wd_i;
	exu_pkg::alu_op_e      alu_op_i;
	exu_pkg::src1_sel_e    src1_sel_i;
	exu_pkg::src2_sel_e    src2_sel_i;
	exu_pkg::data_t        imm_i;
	exu_pkg::data_t        pc_i;
	exu_pkg::store_type_e  store_type_i;
	exu_pkg::load_type_e   load_type_i;
	exu_pkg::branch_type_e branch_type_i;
	logic                  done_o;
	exu_pkg::data_t        result_o;
	logic                  branch_taken_o;

	// expected register contents
	exu_pkg::data_t shadow [32];
	logic           written [32];
	// extra cycles between issue drop and done
	int             done_wait;

	tb_clock u_clock (
		.clk_o (clk_i)
	);

	exu_top i_dut (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.issue_i        (issue_i),
		.rs1_i          (rs1_i),
		.rs2_i          (rs2_i),
		.rd_i           (rd_i),
		.wd_i           (wd_i),
		.alu_op_i       (alu_op_i),
		.src1_sel_i     (src1_sel_i),
		.src2_sel_i     (src2_sel_i),
		.imm_i          (imm_i),
		.pc_i           (pc_i),
		.store_type_i   (store_type_i),
		.load_type_i    (load_type_i),
		.branch_type_i  (branch_type_i),
		.done_o         (done_o),
		.result_o       (result_o),
		.branch_taken_o (branch_taken_o)
	);

	task automatic stop_on_failure();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic compare_data(input string name, input exu_pkg::data_t expected,
		input exu_pkg::data_t actual);
		if (expected !== actual) begin
			$display("Error at %0t: %s expected %h, actual %h",
				$time, name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("Error at %0t: %s expected %b, actual %b",
				$time, name, expected, actual);
			stop_on_failure();
		end
	endtask

	// reference ALU from the operation rules
	function automatic exu_pkg::data_t alu_model(input exu_pkg::alu_op_e op,
		input exu_pkg::data_t a, input exu_pkg::data_t b);
		case (op)
			exu_pkg::alu_add:  return a + b;
			exu_pkg::alu_sub:  return a - b;
			exu_pkg::alu_sll:  return a << b[4:0];
			exu_pkg::alu_srl:  return a >> b[4:0];
			exu_pkg::alu_sra:  return $signed(a) >>> b[4:0];
			exu_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exu_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
			exu_pkg::alu_xor:  return a ^ b;
			exu_pkg::alu_or:   return a | b;
			exu_pkg::alu_and:  return a & b;
			default:           return b;
		endcase
	endfunction

	// old word with the stored lanes replaced
	function automatic exu_pkg::data_t merge_store(input exu_pkg::data_t old,
		input exu_pkg::data_t d, input exu_pkg::store_type_e st, input int off);
		exu_pkg::data_t w;
		w = old;
		for (int i = 0; i < 4; i++) begin
			if ((st == exu_pkg::store_sb && i == off)
				|| (st == exu_pkg::store_sh && (i == off || i == off + 1))) begin
				w[i*8 +: 8] = d[(i-off)*8 +: 8];
			end
		end
		return w;
	endfunction

	function automatic exu_pkg::data_t extend_load(input exu_pkg::load_type_e lt,
		input exu_pkg::data_t word, input int off);
		exu_pkg::data_t v;
		v = word >> (off * 8);
		case (lt)
			exu_pkg::load_lb:  return {{24{v[7]}}, v[7:0]};
			exu_pkg::load_lbu: return {24'b0, v[7:0]};
			exu_pkg::load_lh:  return {{16{v[15]}}, v[15:0]};
			exu_pkg::load_lhu: return {16'b0, v[15:0]};
			default:           return word;
		endcase
	endfunction

	// one instruction, issue for one cycle, then wait for done_o
	task automatic execute(input exu_pkg::reg_addr_t rs1, input exu_pkg::reg_addr_t rs2,
		input exu_pkg::reg_addr_t rd, input logic wd, input exu_pkg::alu_op_e op,
		input exu_pkg::src1_sel_e s1, input exu_pkg::src2_sel_e s2,
		input exu_pkg::data_t imm, input exu_pkg::data_t pc,
		input exu_pkg::store_type_e st, input exu_pkg::load_type_e lt,
		input exu_pkg::branch_type_e bt);
		int waited;
		@(posedge clk_i);
		#10;
		rs1_i         = rs1;
		rs2_i         = rs2;
		rd_i          = rd;
		wd_i          = wd;
		alu_op_i      = op;
		src1_sel_i    = s1;
		src2_sel_i    = s2;
		imm_i         = imm;
		pc_i          = pc;
		store_type_i  = st;
		load_type_i   = lt;
		branch_type_i = bt;
		issue_i       = 1'b1;
		@(posedge clk_i);
		#10;
		issue_i = 1'b0;
		waited  = 0;
		// never more than a few cycles
		while (!done_o && waited < 8) begin
			@(posedge clk_i);
			#10;
			waited++;
		end
		done_wait = waited;
		if (!done_o) begin
			$display("Timeout at %0t: done_o never pulsed after issue", $time);
			stop_on_failure();
		end
	endtask

	task automatic write_reg(input exu_pkg::reg_addr_t rd, input exu_pkg::data_t value);
		execute('0, '0, rd, 1'b1, exu_pkg::alu_pass_b, exu_pkg::src1_zero, exu_pkg::src2_imm,
			value, '0, exu_pkg::store_none, exu_pkg::load_none, exu_pkg::branch_none);
		compare_data("result_o", value, result_o);
		if (rd != '0) begin
			shadow[rd]  = value;
			written[rd] = 1'b1;
		end
	endtask

	// reg plus zero, no writeback
	task automatic check_reg(input exu_pkg::reg_addr_t rs);
		execute(rs, '0, '0, 1'b0, exu_pkg::alu_add, exu_pkg::src1_reg1, exu_pkg::src2_zero,
			'0, '0, exu_pkg::store_none, exu_pkg::load_none, exu_pkg::branch_none);
		compare_data("result_o", shadow[rs], result_o);
		// no branch type, never taken
		compare_bit("branch_taken_o", 1'b0, branch_taken_o);
	endtask

	// address is x30 plus imm, data from x31
	task automatic issue_store(input exu_pkg::store_type_e st, input exu_pkg::data_t imm);
		execute(5'd30, 5'd31, '0, 1'b0, exu_pkg::alu_add, exu_pkg::src1_reg1,
			exu_pkg::src2_imm, imm, '0, st, exu_pkg::load_none, exu_pkg::branch_none);
	endtask

	// load into x6
	task automatic load_check(input exu_pkg::load_type_e lt, input exu_pkg::data_t imm,
		input exu_pkg::data_t expected);
		execute(5'd30, '0, 5'd6, 1'b1, exu_pkg::alu_add, exu_pkg::src1_reg1,
			exu_pkg::src2_imm, imm, '0, exu_pkg::store_none, lt, exu_pkg::branch_none);
		if (done_wait != 1) begin
			$display("Load at %0t finished without the memory read cycle", $time);
			stop_on_failure();
		end
		compare_data("result_o", expected, result_o);
		shadow[6]  = expected;
		written[6] = 1'b1;
	endtask

	task automatic alu_ops();
		exu_pkg::alu_op_e   op;
		exu_pkg::reg_addr_t rs1;
		exu_pkg::reg_addr_t rs2;
		exu_pkg::reg_addr_t rd;
		exu_pkg::data_t     expected;
		int                 k;
		for (int r = 1; r < 9; r++) begin
			write_reg(exu_pkg::reg_addr_t'(r), exu_pkg::data_t'($urandom));
		end
		// x0 write must be dropped
		write_reg('0, exu_pkg::data_t'($urandom));
		k  = 0;
		op = op.first();
		do begin
			rs1 = exu_pkg::reg_addr_t'(1 + k % 8);
			rs2 = exu_pkg::reg_addr_t'(1 + (k + 3) % 8);
			rd  = exu_pkg::reg_addr_t'(16 + k);
			expected = alu_model(op, shadow[rs1], shadow[rs2]);
			execute(rs1, rs2, rd, 1'b1, op, exu_pkg::src1_reg1, exu_pkg::src2_reg2, '0, '0,
				exu_pkg::store_none, exu_pkg::load_none, exu_pkg::branch_none);
			compare_data("result_o", expected, result_o);
			shadow[rd]  = expected;
			written[rd] = 1'b1;
			k++;
			op = op.next();
		end while (op != op.first());
		for (int r = 0; r < 32; r++) begin
			if (r == 0 || written[r]) begin
				check_reg(exu_pkg::reg_addr_t'(r));
			end
		end
	endtask

	task automatic operand_selects();
		exu_pkg::data_t pc;
		exu_pkg::data_t imm;
		pc  = exu_pkg::data_t'($urandom) & 32'hffff_fffc;
		imm = exu_pkg::data_t'($urandom);
		execute('0, '0, '0, 1'b0, exu_pkg::alu_add, exu_pkg::src1_pc, exu_pkg::src2_four,
			'0, pc, exu_pkg::store_none, exu_pkg::load_none, exu_pkg::branch_none);
		compare_data("result_o", pc + 32'd4, result_o);
		execute('0, '0, '0, 1'b0, exu_pkg::alu_add, exu_pkg::src1_pc, exu_pkg::src2_imm,
			imm, pc, exu_pkg::store_none, exu_pkg::load_none, exu_pkg::branch_none);
		compare_data("result_o", pc + imm, result_o);
	endtask

	// all four branch types on x28, x29
	task automatic branch_pair(input exu_pkg::data_t a, input exu_pkg::data_t b);
		exu_pkg::branch_type_e bt;
		logic                  expected;
		write_reg(5'd28, a);
		write_reg(5'd29, b);
		bt = exu_pkg::branch_beq;
		repeat (4) begin
			case (bt)
				exu_pkg::branch_beq: expected = (a == b);
				exu_pkg::branch_bne: expected = (a != b);
				exu_pkg::branch_blt: expected = ($signed(a) < $signed(b));
				default:             expected = ($signed(a) >= $signed(b));
			endcase
			execute(5'd28, 5'd29, '0, 1'b0, exu_pkg::alu_sub, exu_pkg::src1_reg1,
				exu_pkg::src2_reg2, '0, '0, exu_pkg::store_none, exu_pkg::load_none, bt);
			compare_bit("branch_taken_o", expected, branch_taken_o);
			bt = bt.next();
		end
	endtask

	task automatic signed_branches();
		exu_pkg::data_t a;
		exu_pkg::data_t b;
		a = exu_pkg::data_t'($urandom);
		b = exu_pkg::data_t'($urandom);
		if (b == a) begin
			b = ~a;
		end
		branch_pair(a, a);
		branch_pair(a, b);
		branch_pair(b, a);
		// a - b overflows here
		branch_pair(32'h8000_0000, 32'h7fff_ffff);
		branch_pair(32'h7fff_ffff, 32'h8000_0000);
	endtask

	task automatic word_access();
		exu_pkg::data_t base;
		exu_pkg::data_t d;
		exu_pkg::data_t imm;
		repeat (4) begin
			base = exu_pkg::data_t'($urandom_range(0, 127)) << 2;
			imm  = exu_pkg::data_t'($urandom_range(0, 127)) << 2;
			d    = exu_pkg::data_t'($urandom);
			write_reg(5'd30, base);
			write_reg(5'd31, d);
			issue_store(exu_pkg::store_sw, imm);
			load_check(exu_pkg::load_lw, imm, d);
			check_reg(5'd6);
			// load without writeback shows the address and leaves x7 alone
			execute(5'd30, '0, 5'd7, 1'b0, exu_pkg::alu_add, exu_pkg::src1_reg1,
				exu_pkg::src2_imm, imm, '0, exu_pkg::store_none, exu_pkg::load_lw,
				exu_pkg::branch_none);
			compare_data("result_o", base + imm, result_o);
			check_reg(5'd7);
		end
	endtask

	task automatic subword_access();
		exu_pkg::data_t       base;
		exu_pkg::data_t       pattern;
		exu_pkg::data_t       d;
		exu_pkg::data_t       merged;
		exu_pkg::data_t       off;
		exu_pkg::store_type_e st;
		st = exu_pkg::store_sb;
		repeat (2) begin
			for (int o = 0; o < 4; o++) begin
				// halfwords only at aligned offsets
				if (st == exu_pkg::store_sb || o % 2 == 0) begin
					off     = exu_pkg::data_t'(o);
					base    = exu_pkg::data_t'($urandom_range(0, 255)) << 2;
					// pattern tied to the word address
					pattern = {base[9:2], ~base[9:2], base[9:2] ^ 8'h5a, 8'hc3};
					d       = exu_pkg::data_t'($urandom);
					d[7]    = off[0];
					d[15]   = off[1];
					write_reg(5'd30, base);
					write_reg(5'd31, pattern);
					issue_store(exu_pkg::store_sw, '0);
					write_reg(5'd31, d);
					issue_store(st, off);
					merged = merge_store(pattern, d, st, o);
					load_check(exu_pkg::load_lw, '0, merged);
					load_check(exu_pkg::load_lb, off,
						extend_load(exu_pkg::load_lb, merged, o));
					load_check(exu_pkg::load_lbu, off,
						extend_load(exu_pkg::load_lbu, merged, o));
					if (o % 2 == 0) begin
						load_check(exu_pkg::load_lh, off,
							extend_load(exu_pkg::load_lh, merged, o));
						load_check(exu_pkg::load_lhu, off,
							extend_load(exu_pkg::load_lhu, merged, o));
					end
				end
			end
			st = exu_pkg::store_sh;
		end
	endtask

	initial begin
		void'($urandom(32'hc13b8c31));
		rst_n_i       = 1'b0;
		issue_i       = 1'b0;
		rs1_i         = '0;
		rs2_i         = '0;
		rd_i          = '0;
		wd_i          = 1'b0;
		alu_op_i      = exu_pkg::alu_add;
		src1_sel_i    = exu_pkg::src1_zero;
		src2_sel_i    = exu_pkg::src2_zero;
		imm_i         = '0;
		pc_i          = '0;
		store_type_i  = exu_pkg::store_none;
		load_type_i   = exu_pkg::load_none;
		branch_type_i = exu_pkg::branch_none;
		done_wait     = 0;
		for (int r = 0; r < 32; r++) begin
			shadow[r]  = '0;
			written[r] = 1'b0;
		end
		repeat (4) @(posedge clk_i);
		#10;
		rst_n_i = 1'b1;
		// outputs cleared by reset
		compare_bit("done_o", 1'b0, done_o);
		compare_bit("branch_taken_o", 1'b0, branch_taken_o);
		compare_data("result_o", '0, result_o);
		alu_ops();
		operand_selects();
		signed_branches();
		word_access();
		subword_access();
		$display("All tests passed");
		$finish;
	end

endmodule

//--- exu_props.sv
/*
 * exu_props
 * issue and done protocol checks, bound into exu_top
 */
`timescale 1ns/10ps
module exu_props (
	input logic                clk_i,
	input logic                rst_n_i,
	input logic                issue_i,
	input exu_pkg::load_type_e load_type_i,
	input logic                done_i
);

	// plain ops finish on the next edge
	property plain_done;
		@(posedge clk_i) disable iff (!rst_n_i)
		issue_i && (load_type_i == exu_pkg::load_none) |=> done_i;
	endproperty

	// loads take the extra memory read cycle
	property load_done;
		@(posedge clk_i) disable iff (!rst_n_i)
		issue_i && (load_type_i != exu_pkg::load_none) |=> !done_i ##1 done_i;
	endproperty

	// a load in flight blocks the next issue
	property no_issue_busy;
		@(posedge clk_i) disable iff (!rst_n_i)
		issue_i && (load_type_i != exu_pkg::load_none) |=> !issue_i;
	endproperty

	property done_in_reset;
		@(posedge clk_i) !rst_n_i |=> !done_i;
	endproperty

	assert property (plain_done) else $error("done_o missing after a non-load issue");
	assert property (load_done) else $error("done_o not two cycles after a load issue");
	assert property (no_issue_busy) else $error("issue while a load is in flight");
	assert property (done_in_reset) else $error("done_o high during reset");

endmodule

bind exu_top exu_props u_props (
	.clk_i       (clk_i),
	.rst_n_i     (rst_n_i),
	.issue_i     (issue_i),
	.load_type_i (load_type_i),
	.done_i      (done_o)
);

//--- tb_clock.sv
/*
 * tb_clock
 * free running testbench clock, 100 ns period
 */
`timescale 1ns/10ps
module tb_clock (
	output logic clk_o
);

	// half period of 50 ns
	initial begin
		clk_o = 1'b0;
		forever begin
			#50;
			clk_o = ~clk_o;
		end
	end

endmodule

//--- exu_top.sv
/*
 * exu_top
 * execute cluster: register file, execute stage and load/store unit
 */
`timescale 1ns/10ps
module exu_top (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  issue_i,
	input  exu_pkg::reg_addr_t    rs1_i,
	input  exu_pkg::reg_addr_t    rs2_i,
	input  exu_pkg::reg_addr_t    rd_i,
	input  logic                  wd_i,
	input  exu_pkg::alu_op_e      alu_op_i,
	input  exu_pkg::src1_sel_e    src1_sel_i,
	input  exu_pkg::src2_sel_e    src2_sel_i,
	input  exu_pkg::data_t        imm_i,
	input  exu_pkg::data_t        pc_i,
	input  exu_pkg::store_type_e  store_type_i,
	input  exu_pkg::load_type_e   load_type_i,
	input  exu_pkg::branch_type_e branch_type_i,
	output logic                  done_o,
	output exu_pkg::data_t        result_o,
	output logic                  branch_taken_o
);

	exu_pkg::data_t     rdata1;
	exu_pkg::data_t     rdata2;
	exu_pkg::data_t     alu_result;
	logic               branch_taken;
	logic               mem_wen;
	exu_pkg::data_t     mem_wdata;
	exu_pkg::byte_en_t  mem_be;
	// writeback path from the lsu
	logic               rf_we;
	exu_pkg::reg_addr_t rf_waddr;
	exu_pkg::data_t     rf_wdata;

	regfile u_regfile (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.raddr1_i (rs1_i),
		.raddr2_i (rs2_i),
		.waddr_i  (rf_waddr),
		.we_i     (rf_we),
		.wdata_i  (rf_wdata),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	exu u_exu (
		.reg1_i         (rdata1),
		.reg2_i         (rdata2),
		.pc_i           (pc_i),
		.imm_i          (imm_i),
		.alu_op_i       (alu_op_i),
		.src1_sel_i     (src1_sel_i),
		.src2_sel_i     (src2_sel_i),
		.store_type_i   (store_type_i),
		.branch_type_i  (branch_type_i),
		.alu_result_o   (alu_result),
		.branch_taken_o (branch_taken),
		.mem_wen_o      (mem_wen),
		.mem_wdata_o    (mem_wdata),
		.mem_be_o       (mem_be)
	);

	lsu u_lsu (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.issue_i        (issue_i),
		.load_type_i    (load_type_i),
		.wd_i           (wd_i),
		.rd_i           (rd_i),
		.alu_result_i   (alu_result),
		.branch_taken_i (branch_taken),
		.mem_wen_i      (mem_wen),
		.mem_wdata_i    (mem_wdata),
		.mem_be_i       (mem_be),
		.rf_we_o        (rf_we),
		.rf_waddr_o     (rf_waddr),
		.rf_wdata_o     (rf_wdata),
		.done_o         (done_o),
		.branch_taken_o (branch_taken_o),
		.result_o       (result_o)
	);

endmodule

//--- lsu.sv
/*
 * lsu
 * 256-word data memory with byte-enable writes and registered read,
 * load extension, register writeback and the done pulse per instruction
 */
`timescale 1ns/10ps
module lsu (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 issue_i,
	input  exu_pkg::load_type_e  load_type_i,
	input  logic                 wd_i,
	input  exu_pkg::reg_addr_t   rd_i,
	input  exu_pkg::data_t       alu_result_i,
	input  logic                 branch_taken_i,
	input  logic                 mem_wen_i,
	input  exu_pkg::data_t       mem_wdata_i,
	input  exu_pkg::byte_en_t    mem_be_i,
	output logic                 rf_we_o,
	output exu_pkg::reg_addr_t   rf_waddr_o,
	output exu_pkg::data_t       rf_wdata_o,
	output logic                 done_o,
	output logic                 branch_taken_o,
	output exu_pkg::data_t       result_o
);

	typedef enum logic {idle, load_wait} state_e;

	state_e                          state;
	exu_pkg::data_t                  mem [2**exu_pkg::MEM_ADDR_LEN];
	exu_pkg::data_t                  rdata_q;
	exu_pkg::data_t                  lane;
	exu_pkg::data_t                  load_ext;
	logic [exu_pkg::MEM_ADDR_LEN-1:0] word_addr;
	logic                            is_load;
	logic                            finish;

	assign word_addr = alu_result_i[exu_pkg::MEM_ADDR_LEN+1:2];
	assign is_load   = (load_type_i != exu_pkg::load_none);
	// one edge for plain ops, two for loads
	assign finish    = (state == load_wait) || (issue_i && !is_load);

	// store lanes and load read both on the issue edge
	always_ff @(posedge clk_i) begin
		if (issue_i && mem_wen_i) begin
			for (int b = 0; b < exu_pkg::DATA_LEN/8; b++) begin
				if (mem_be_i[b]) begin
					mem[word_addr][b*8 +: 8] <= mem_wdata_i[b*8 +: 8];
				end
			end
		end
		if (issue_i && is_load) begin
			rdata_q <= mem[word_addr];
		end
	end

	// addressed byte or half down to bit 0
	assign lane = rdata_q >> {alu_result_i[1:0], 3'b000};

	always_comb begin
		case (load_type_i)
			exu_pkg::load_lb:  load_ext = {{24{lane[7]}}, lane[7:0]};
			exu_pkg::load_lh:  load_ext = {{16{lane[15]}}, lane[15:0]};
			exu_pkg::load_lbu: load_ext = {24'b0, lane[7:0]};
			exu_pkg::load_lhu: load_ext = {16'b0, lane[15:0]};
			default:           load_ext = rdata_q;
		endcase
	end

	// writeback source follows the state
	assign rf_wdata_o = (state == load_wait) ? load_ext : alu_result_i;
	assign rf_waddr_o = rd_i;
	assign rf_we_o    = finish && wd_i;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state          <= idle;
			done_o         <= 1'b0;
			branch_taken_o <= 1'b0;
			result_o       <= '0;
		end else begin
			if (state == idle && issue_i && is_load) begin
				state <= load_wait;
			end else begin
				state <= idle;
			end
			done_o         <= finish;
			branch_taken_o <= finish && branch_taken_i;
			if (finish) begin
				result_o <= wd_i ? rf_wdata_o : alu_result_i;
			end
		end
	end

endmodule

//--- regfile.sv
/*
 * regfile
 * 32 x 32 register file, two combinational reads, one synchronous write
 * x0 always reads zero
 */
`timescale 1ns/10ps
module regfile (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  exu_pkg::reg_addr_t raddr1_i,
	input  exu_pkg::reg_addr_t raddr2_i,
	input  exu_pkg::reg_addr_t waddr_i,
	input  logic               we_i,
	input  exu_pkg::data_t     wdata_i,
	output exu_pkg::data_t     rdata1_o,
	output exu_pkg::data_t     rdata2_o
);

	// x1..x31 only, no storage for x0
	exu_pkg::data_t regs [1:31];

	// no writes while reset is held, contents kept
	always_ff @(posedge clk_i) begin
		if (rst_n_i && we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// x0 decoded to zero on the read side
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- exu.sv
/*
 * exu
 * execute stage: operand select, ALU, branch decision from the ALU flags,
 * store data placement and byte enables for the data memory
 */
`timescale 1ns/10ps
module exu (
	input  exu_pkg::data_t        reg1_i,
	input  exu_pkg::data_t        reg2_i,
	input  exu_pkg::data_t        pc_i,
	input  exu_pkg::data_t        imm_i,
	input  exu_pkg::alu_op_e      alu_op_i,
	input  exu_pkg::src1_sel_e    src1_sel_i,
	input  exu_pkg::src2_sel_e    src2_sel_i,
	input  exu_pkg::store_type_e  store_type_i,
	input  exu_pkg::branch_type_e branch_type_i,
	output exu_pkg::data_t        alu_result_o,
	output logic                  branch_taken_o,
	output logic                  mem_wen_o,
	output exu_pkg::data_t        mem_wdata_o,
	output exu_pkg::byte_en_t     mem_be_o
);

	exu_pkg::data_t    src1;
	exu_pkg::data_t    src2;
	exu_pkg::data_t    data_mask;
	exu_pkg::byte_en_t be_base;
	logic              alu_zero;
	logic              alu_sign;
	logic [1:0]        offset;

	// operand muxes
	always_comb begin
		case (src1_sel_i)
			exu_pkg::src1_reg1: src1 = reg1_i;
			exu_pkg::src1_pc:   src1 = pc_i;
			default:            src1 = '0;
		endcase
		case (src2_sel_i)
			exu_pkg::src2_reg2: src2 = reg2_i;
			exu_pkg::src2_imm:  src2 = imm_i;
			exu_pkg::src2_four: src2 = exu_pkg::data_t'(4);
			default:            src2 = '0;
		endcase
	end

	alu u_alu (
		.src1_i   (src1),
		.src2_i   (src2),
		.alu_op_i (alu_op_i),
		.result_o (alu_result_o),
		.zero_o   (alu_zero),
		.sign_o   (alu_sign)
	);

	// beq/bne on the zero flag, blt/bge on the signed flag
	always_comb begin
		case (branch_type_i)
			exu_pkg::branch_beq: branch_taken_o = alu_zero;
			exu_pkg::branch_bne: branch_taken_o = ~alu_zero;
			exu_pkg::branch_blt: branch_taken_o = alu_sign;
			exu_pkg::branch_bge: branch_taken_o = ~alu_sign;
			default:             branch_taken_o = 1'b0;
		endcase
	end

	// byte offset inside the word
	assign offset    = alu_result_o[1:0];
	assign mem_wen_o = (store_type_i != exu_pkg::store_none);

	always_comb begin
		case (store_type_i)
			exu_pkg::store_sb: begin
				data_mask = 32'h0000_00ff;
				be_base   = 4'b0001;
			end
			exu_pkg::store_sh: begin
				data_mask = 32'h0000_ffff;
				be_base   = 4'b0011;
			end
			exu_pkg::store_sw: begin
				data_mask = 32'hffff_ffff;
				be_base   = 4'b1111;
			end
			default: begin
				data_mask = '0;
				be_base   = '0;
			end
		endcase
	end

	// move data and enables up to the addressed lanes
	assign mem_wdata_o = (reg2_i & data_mask) << {offset, 3'b000};
	assign mem_be_o    = be_base << offset;

endmodule

//--- alu.sv
/*
 * alu
 * combinational add, sub, shift, compare and logic unit
 * zero flag on the result, signed less-than flag on the operands
 */
`timescale 1ns/10ps
module alu (
	input  exu_pkg::data_t   src1_i,
	input  exu_pkg::data_t   src2_i,
	input  exu_pkg::alu_op_e alu_op_i,
	output exu_pkg::data_t   result_o,
	output logic             zero_o,
	output logic             sign_o
);

	// one extra bit so the compare never overflows
	logic [exu_pkg::DATA_LEN:0] diff_s;
	logic [exu_pkg::DATA_LEN:0] diff_u;
	logic                       lt_s;
	logic                       lt_u;
	logic [4:0]                 shamt;

	// sign extended operands for the signed compare
	assign diff_s = {src1_i[exu_pkg::DATA_LEN-1], src1_i}
		- {src2_i[exu_pkg::DATA_LEN-1], src2_i};
	// zero extended operands, top bit is the borrow
	assign diff_u = {1'b0, src1_i} - {1'b0, src2_i};
	assign lt_s   = diff_s[exu_pkg::DATA_LEN];
	assign lt_u   = diff_u[exu_pkg::DATA_LEN];
	assign shamt  = src2_i[4:0];

	always_comb begin
		case (alu_op_i)
			exu_pkg::alu_add:    result_o = src1_i + src2_i;
			exu_pkg::alu_sub:    result_o = src1_i - src2_i;
			exu_pkg::alu_sll:    result_o = src1_i << shamt;
			exu_pkg::alu_slt:    result_o = {{(exu_pkg::DATA_LEN-1){1'b0}}, lt_s};
			exu_pkg::alu_sltu:   result_o = {{(exu_pkg::DATA_LEN-1){1'b0}}, lt_u};
			exu_pkg::alu_xor:    result_o = src1_i ^ src2_i;
			exu_pkg::alu_srl:    result_o = src1_i >> shamt;
			// arithmetic shift keeps the sign bit
			exu_pkg::alu_sra:    result_o = $signed(src1_i) >>> shamt;
			exu_pkg::alu_or:     result_o = src1_i | src2_i;
			exu_pkg::alu_and:    result_o = src1_i & src2_i;
			exu_pkg::alu_pass_b: result_o = src2_i;
			default:             result_o = '0;
		endcase
	end

	// flags for the branch decision
	assign zero_o = (result_o == '0);
	// signed a < b, independent of the selected op
	assign sign_o = lt_s;

endmodule

//--- exu_pkg.sv
/*
 * exu package
 * widths, ALU operation codes, operand select, store, load and branch codes
 * and the vector types shared by the execute cluster
 */
package exu_pkg;

	// data path and register index widths
	localparam int DATA_LEN     = 32;
	localparam int REG_ADDR_LEN = 5;
	// word address into the data memory, 256 words
	localparam int MEM_ADDR_LEN = 8;

	typedef logic [DATA_LEN-1:0]     data_t;
	typedef logic [REG_ADDR_LEN-1:0] reg_addr_t;
	typedef logic [DATA_LEN/8-1:0]   byte_en_t;

	// ALU operations, shifts take src2[4:0]
	typedef enum logic [3:0] {
		alu_add    = 4'b0000,
		alu_sub    = 4'b0001,
		alu_sll    = 4'b0010,
		alu_slt    = 4'b0011,
		alu_sltu   = 4'b0100,
		alu_xor    = 4'b0101,
		alu_srl    = 4'b0110,
		alu_sra    = 4'b0111,
		alu_or     = 4'b1000,
		alu_and    = 4'b1001,
		alu_pass_b = 4'b1010
	} alu_op_e;

	// first operand source
	typedef enum logic [1:0] {
		src1_zero = 2'b00,
		src1_reg1 = 2'b01,
		src1_pc   = 2'b10
	} src1_sel_e;

	// second operand source
	typedef enum logic [1:0] {
		src2_zero = 2'b00,
		src2_reg2 = 2'b01,
		src2_imm  = 2'b10,
		src2_four = 2'b11
	} src2_sel_e;

	// none is zero, any other code is a store
	typedef enum logic [1:0] {
		store_none = 2'b00,
		store_sb   = 2'b01,
		store_sh   = 2'b10,
		store_sw   = 2'b11
	} store_type_e;

	typedef enum logic [2:0] {
		load_none = 3'b000,
		load_lb   = 3'b001,
		load_lh   = 3'b010,
		load_lw   = 3'b011,
		load_lbu  = 3'b100,
		load_lhu  = 3'b101
	} load_type_e;

	// signed compares only
	typedef enum logic [2:0] {
		branch_none = 3'b000,
		branch_beq  = 3'b001,
		branch_bne  = 3'b010,
		branch_blt  = 3'b011,
		branch_bge  = 3'b100
	} branch_type_e;

endpackage
